// ==== src.f ====
+incdir+verilog
verilog/telemetry_pkg.sv
verilog/acq_sequencer.sv
verilog/sample_buffer.sv
verilog/serial_framer.sv
verilog/telemetry_top.sv
tests/telemetry_assertions.sv
tests/telemetry_tb.sv

// ==== Makefile ====
TOP = telemetry_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o Vtb

run: compile
	./obj_dir/Vtb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/telemetry_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// telemetry testbench
// random ADC model, serial decoder and scoreboard
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "telemetry_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module telemetry_tb;
	import telemetry_pkg::*;

	localparam int NUM_FRAMES = 40;
	localparam int FRAME_CYCLES = 10 * `TEL_BIT_CYCLES;
	// bare frame time, six times over for dsr low spans, plus reset and fill
	localparam int MAX_CYCLES = NUM_FRAMES * FRAME_CYCLES * 6 + 800;

	logic clock;
	logic rst_n;
	logic mux_en;
	logic [`TEL_CHAN_W-1:0] channel;
	logic soc;
	logic eoc;
	sample_t data_in;
	logic dsr;
	logic data_out;

	// scoreboard, samples in capture order
	sample_t expected[$];
	int exp_chan;
	int errors;
	int samples;
	int frames;
	int cycles;
	bit run_done;
	int eoc_wait;
	int dsr_hold;
	// cycles with mux_en low while a slot is free
	int idle_span;
	// serial decoder state
	bit in_frame;
	bit prev_line;
	int bit_timer;
	int bit_num;
	sample_t rx_data;

	telemetry_top DUT (
		.clock    (clock),
		.rst_n    (rst_n),
		.mux_en   (mux_en),
		.channel  (channel),
		.soc      (soc),
		.eoc      (eoc),
		.data_in  (data_in),
		.dsr      (dsr),
		.data_out (data_out)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// soc checks, then eoc with a fresh sample 1 to 6 cycles later
	task automatic adc_step();
		eoc = 1'b0;
		if (soc) begin
			if (mux_en !== 1'b1) begin
				$display("** Error: mux_en at soc: got 0x%h expected 0x1", mux_en);
				errors++;
			end
			if (int'(channel) != exp_chan) begin
				$display("** Error: channel at soc: got 0x%h expected 0x%h",
					channel, exp_chan[`TEL_CHAN_W-1:0]);
				errors++;
			end
			// unsent samples already fill every buffer slot
			if (samples - frames >= `TEL_BUF_DEPTH) begin
				$display("soc issued with %0d unsent samples and no free slot",
					samples - frames);
				errors++;
			end
			exp_chan = (exp_chan + 1) % `TEL_NUM_CHANNELS;
			eoc_wait = 1 + int'($urandom % 6);
		end else if (eoc_wait > 0) begin
			eoc_wait--;
			if (eoc_wait == 0) begin
				eoc = 1'b1;
				data_in = 8'($urandom);
				expected.push_back(data_in);
				samples++;
			end
		end
	endtask

	// a free slot restarts the scan within one bit period
	// covers the credit lag from mid stop bit to its end
	task automatic scan_progress_step();
		if (mux_en || samples - frames >= `TEL_BUF_DEPTH) begin
			idle_span = 0;
		end else begin
			idle_span++;
			if (idle_span > `TEL_BIT_CYCLES) begin
				$display("scan stalled %0d cycles with only %0d unsent samples",
					idle_span, samples - frames);
				errors++;
				idle_span = 0;
			end
		end
	endtask

	// oldest captured sample must match the decoded byte
	task automatic compare_frame();
		sample_t want;
		if (expected.size() == 0) begin
			$display("frame 0x%h decoded with no captured sample left", rx_data);
			errors++;
		end else begin
			want = expected.pop_front();
			if (rx_data !== want) begin
				$display("** Error: data_out frame %0d: got 0x%h expected 0x%h",
					frames, rx_data, want);
				errors++;
			end
		end
		frames++;
	endtask

	// falling edge opens a frame, each bit sampled mid period
	task automatic decode_step();
		if (!in_frame) begin
			if (prev_line && !data_out) begin
				if (!dsr) begin
					$display("start bit began while dsr was low");
					errors++;
				end
				in_frame = 1'b1;
				bit_timer = `TEL_BIT_CYCLES / 2;
				bit_num = 0;
			end
		end else begin
			bit_timer--;
			if (bit_timer == 0) begin
				bit_timer = `TEL_BIT_CYCLES;
				if (bit_num == 0) begin
					if (data_out !== 1'b0) begin
						$display("** Error: data_out start bit: got 0x%h expected 0x0",
							data_out);
						errors++;
					end
				end else if (bit_num <= 8) begin
					rx_data = {rx_data[6:0], data_out};
				end else begin
					if (data_out !== 1'b1) begin
						$display("** Error: data_out stop bit: got 0x%h expected 0x1",
							data_out);
						errors++;
					end
					compare_frame();
					in_frame = 1'b0;
				end
				bit_num++;
			end
		end
		prev_line = data_out;
	endtask

	// long random spans, ready about two thirds of the time
	task automatic dsr_step();
		if (dsr_hold > 0) begin
			dsr_hold--;
		end else begin
			dsr = ($urandom % 3) != 0;
			dsr_hold = 50 + int'($urandom % 350);
		end
	endtask

	// outputs held at their reset levels
	task automatic check_reset_outputs();
		if (mux_en !== 1'b0) begin
			$display("** Error: mux_en in reset: got 0x%h expected 0x0", mux_en);
			errors++;
		end
		if (soc !== 1'b0) begin
			$display("** Error: soc in reset: got 0x%h expected 0x0", soc);
			errors++;
		end
		if (data_out !== 1'b1) begin
			$display("** Error: data_out in reset: got 0x%h expected 0x1", data_out);
			errors++;
		end
	endtask

	// decode before dsr moves, so dsr is the value seen at the last edge
	always @(negedge clock) begin
		if (rst_n && !run_done) begin
			adc_step();
			decode_step();
			scan_progress_step();
			dsr_step();
		end
	end

	initial begin
		void'($urandom(48));
		rst_n = 1'b0;
		eoc = 1'b0;
		data_in = '0;
		dsr = 1'b1;
		exp_chan = 0;
		errors = 0;
		samples = 0;
		frames = 0;
		cycles = 0;
		run_done = 1'b0;
		eoc_wait = 0;
		dsr_hold = 0;
		idle_span = 0;
		in_frame = 1'b0;
		prev_line = 1'b1;
		bit_timer = 0;
		bit_num = 0;
		rx_data = '0;
		repeat (5) begin
			@(negedge clock);
			check_reset_outputs();
		end
		rst_n <= 1'b1;
		while (frames < NUM_FRAMES && cycles < MAX_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		run_done = 1'b1;
		if (frames < NUM_FRAMES) begin
			$display("timeout after %0d cycles with %0d of %0d frames received",
				cycles, frames, NUM_FRAMES);
			errors++;
		end
		$display("errors %0d, frames %0d, samples %0d, cycles %0d",
			errors, frames, samples, cycles);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// run ended before the closing summary
	final begin
		if (!run_done) begin
			$display("=== FAIL ===");
		end
	end

endmodule

`default_nettype wire

// ==== tests/telemetry_assertions.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// telemetry assertions
// protocol properties bound into the sequencer and framer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "telemetry_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module telemetry_assertions (
	input logic                                 clock,
	input logic                                 rst_n,
	input logic                                 mux_en,
	input logic                                 soc,
	input logic                                 push,
	input logic [$clog2(`TEL_BUF_DEPTH + 1)-1:0] credits,
	input telemetry_pkg::frame_bit_t            frm_state,
	input logic                                 data_out
);
	import telemetry_pkg::*;

	// conversion only starts with the mux driving the ADC
	soc_with_mux: assert property (@(posedge clock) disable iff (!rst_n) soc |-> mux_en)
		else $error("soc high while mux_en is low");

	// returned credits never exceed the free buffer slots
	credit_bound: assert property (@(posedge clock) disable iff (!rst_n)
		credits <= `TEL_BUF_DEPTH)
		else $error("credit count above buffer depth");

	// every push was paid for with a credit
	push_paid: assert property (@(posedge clock) disable iff (!rst_n)
		push |-> (credits != '0))
		else $error("push with no credit left");

	// line idles high between frames
	idle_high: assert property (@(posedge clock) disable iff (!rst_n)
		(frm_state == FRM_IDLE) |-> data_out)
		else $error("data_out low while framer idle");

endmodule

// sequencer side, framer inputs tied to a harmless state
bind acq_sequencer telemetry_assertions seq_checks (
	.clock     (clock),
	.rst_n     (rst_n),
	.mux_en    (mux_en),
	.soc       (soc),
	.push      (push),
	.credits   (credits),
	.frm_state (telemetry_pkg::FRM_STOP),
	.data_out  (1'b1)
);

// framer side, sequencer inputs tied idle
bind serial_framer telemetry_assertions framer_checks (
	.clock     (clock),
	.rst_n     (rst_n),
	.mux_en    (1'b0),
	.soc       (1'b0),
	.push      (1'b0),
	.credits   ('0),
	.frm_state (state),
	.data_out  (data_out)
);

`default_nettype wire

// ==== verilog/telemetry_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// telemetry top
// scan sequencer, sample buffer and serial framer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "telemetry_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module telemetry_top (
	input  logic                   clock,
	input  logic                   rst_n,
	output logic                   mux_en,
	output logic [`TEL_CHAN_W-1:0] channel,
	output logic                   soc,
	input  logic                   eoc,
	input  telemetry_pkg::sample_t data_in,
	input  logic                   dsr,
	output logic                   data_out
);
	import telemetry_pkg::*;

	// sequencer to buffer
	logic push;
	sample_t push_data;

	// buffer to framer
	logic pop;
	logic pop_valid;
	sample_t pop_data;

	// framer back to sequencer
	logic credit_return;

	acq_sequencer u_seq (
		.clock         (clock),
		.rst_n         (rst_n),
		.eoc           (eoc),
		.data_in       (data_in),
		.credit_return (credit_return),
		.mux_en        (mux_en),
		.soc           (soc),
		.channel       (channel),
		.push          (push),
		.push_data     (push_data)
	);

	sample_buffer u_buf (
		.clock     (clock),
		.rst_n     (rst_n),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_valid (pop_valid),
		.pop_data  (pop_data)
	);

	serial_framer u_framer (
		.clock         (clock),
		.rst_n         (rst_n),
		.pop_valid     (pop_valid),
		.pop_data      (pop_data),
		.dsr           (dsr),
		.pop           (pop),
		.credit_return (credit_return),
		.data_out      (data_out)
	);

endmodule

`default_nettype wire

// ==== verilog/serial_framer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial framer
// start, 8 data bits msb first, stop, each bit held for a
// fixed clock count, one credit returned per frame
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "telemetry_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module serial_framer (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   pop_valid,
	input  telemetry_pkg::sample_t pop_data,
	input  logic                   dsr,
	output logic                   pop,
	output logic                   credit_return,
	output logic                   data_out
);
	import telemetry_pkg::*;

	localparam int DATA_BITS = $bits(sample_t);
	localparam int IDX_W = $clog2(DATA_BITS);
	localparam int DIV_W = (`TEL_BIT_CYCLES > 1) ? $clog2(`TEL_BIT_CYCLES) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`TEL_BIT_CYCLES - 1);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_BITS - 1);

	frame_bit_t state;
	logic [DIV_W-1:0] div_cnt;
	logic [IDX_W-1:0] bit_idx;
	sample_t shift_reg;
	logic bit_end;

	// last clock of the current bit period
	assign bit_end = (div_cnt == DIV_LAST);

	// take the head entry only when the terminal is ready
	assign pop = (state == FRM_IDLE) && pop_valid && dsr;

	// slot is free again once the stop bit has fully gone out
	assign credit_return = (state == FRM_STOP) && bit_end;

	// frame position, bit divider and line level
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= FRM_IDLE;
			div_cnt <= '0;
			bit_idx <= '0;
			data_out <= 1'b1;
		end else begin
			// divider runs only inside a frame
			if (state == FRM_IDLE || bit_end) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			case (state)
				FRM_IDLE: begin
					data_out <= 1'b1;
					if (pop) begin
						data_out <= 1'b0;
						state <= FRM_START;
					end
				end
				FRM_START: begin
					if (bit_end) begin
						bit_idx <= '0;
						data_out <= shift_reg[DATA_BITS-1];
						state <= FRM_DATA;
					end
				end
				FRM_DATA: begin
					if (bit_end) begin
						if (bit_idx == IDX_LAST) begin
							data_out <= 1'b1;
							state <= FRM_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							data_out <= shift_reg[DATA_BITS-1];
						end
					end
				end
				FRM_STOP: begin
					if (bit_end) begin
						state <= FRM_IDLE;
					end
				end
				default: begin
					state <= FRM_IDLE;
				end
			endcase
		end
	end

	// shift register, msb leaves first
	always_ff @(posedge clock) begin
		if (pop) begin
			shift_reg <= pop_data;
		end else if (bit_end && (state == FRM_START || state == FRM_DATA)) begin
			shift_reg <= {shift_reg[DATA_BITS-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sample_buffer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample buffer
// circular FIFO between the sequencer and the framer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "telemetry_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module sample_buffer (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   push,
	input  telemetry_pkg::sample_t push_data,
	input  logic                   pop,
	output logic                   pop_valid,
	output telemetry_pkg::sample_t pop_data
);
	import telemetry_pkg::*;

	localparam int DEPTH = `TEL_BUF_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

	sample_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_pop;

	// head entry is valid whenever something is stored
	assign pop_valid = (count != '0);
	assign pop_data = mem[rd_ptr];

	// ignore a pop on an empty buffer
	assign do_pop = pop && pop_valid;

	// storage
	// no full check, the credit count keeps pushes within DEPTH
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// pointers wrap at DEPTH
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// occupancy
	// simultaneous push and pop leave it unchanged
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/acq_sequencer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// acquisition sequencer
// steps the mux, runs the ADC soc/eoc handshake, captures
// samples and spends one credit per pushed sample
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "telemetry_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module acq_sequencer (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   eoc,
	input  telemetry_pkg::sample_t data_in,
	input  logic                   credit_return,
	output logic                   mux_en,
	output logic                   soc,
	output logic [`TEL_CHAN_W-1:0] channel,
	output logic                   push,
	output telemetry_pkg::sample_t push_data
);
	import telemetry_pkg::*;

	localparam int CHAN_W = `TEL_CHAN_W;
	localparam int CREDIT_W = $clog2(`TEL_BUF_DEPTH + 1);
	// cycles the mux is held before soc
	localparam int SETTLE_CYCLES = 2;
	localparam int SETTLE_W = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;

	localparam logic [CHAN_W-1:0] LAST_CHANNEL = CHAN_W'(`TEL_NUM_CHANNELS - 1);
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`TEL_BUF_DEPTH);
	localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(SETTLE_CYCLES - 1);

	acq_state_t state;
	logic [SETTLE_W-1:0] settle_cnt;
	logic [CREDIT_W-1:0] credits;
	logic has_credit;
	logic capture;
	logic [CHAN_W-1:0] channel_next;

	// a conversion may only begin with a free slot reserved
	assign has_credit = (credits != '0);

	// end of conversion seen while converting
	assign capture = (state == ACQ_CONVERT) && eoc;

	// channel step with wrap after the last mux input
	assign channel_next = (channel == LAST_CHANNEL) ? '0 : channel + 1'b1;

	// scan FSM, soc and push are single cycle pulses
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= ACQ_IDLE;
			settle_cnt <= '0;
			mux_en <= 1'b0;
			soc <= 1'b0;
			push <= 1'b0;
			channel <= '0;
		end else begin
			soc <= 1'b0;
			push <= 1'b0;
			case (state)
				ACQ_IDLE: begin
					// no credit means back-pressure, mux stays off
					if (has_credit) begin
						mux_en <= 1'b1;
						settle_cnt <= '0;
						state <= ACQ_SETTLE;
					end
				end
				ACQ_SETTLE: begin
					if (settle_cnt == SETTLE_LAST) begin
						soc <= 1'b1;
						state <= ACQ_CONVERT;
					end else begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
				ACQ_CONVERT: begin
					// data_in is valid in the eoc cycle only
					if (capture) begin
						mux_en <= 1'b0;
						push <= 1'b1;
						channel <= channel_next;
						state <= ACQ_ADVANCE;
					end
				end
				ACQ_ADVANCE: begin
					state <= ACQ_IDLE;
				end
				default: begin
					state <= ACQ_IDLE;
				end
			endcase
		end
	end

	// sample register, loaded on eoc
	always_ff @(posedge clock) begin
		if (capture) begin
			push_data <= data_in;
		end
	end

	// credit count
	// one spent per push, one back per finished frame
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CREDIT_MAX;
		end else begin
			case ({push, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/telemetry_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// telemetry package
// sample type and the state encodings of scan and framer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package telemetry_pkg;

	// one ADC conversion result
	typedef logic [7:0] sample_t;

	// scan sequencer states
	typedef enum logic [1:0] {
		// waiting for a free buffer credit
		ACQ_IDLE    = 2'd0,
		// mux enabled, analog input settling
		ACQ_SETTLE  = 2'd1,
		// soc issued, waiting for eoc
		ACQ_CONVERT = 2'd2,
		// sample pushed, channel stepped
		ACQ_ADVANCE = 2'd3
	} acq_state_t;

	// position of the transmitter inside a frame
	typedef enum logic [1:0] {
		// line idles high
		FRM_IDLE  = 2'd0,
		// start bit, line low
		FRM_START = 2'd1,
		// eight data bits, msb first
		FRM_DATA  = 2'd2,
		// stop bit, line high
		FRM_STOP  = 2'd3
	} frame_bit_t;

endpackage

`default_nettype wire

// ==== verilog/telemetry_consts.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// telemetry constants
// channel scan, buffer sizing and serial bit timing
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TELEMETRY_CONSTS_SVH
`define TELEMETRY_CONSTS_SVH

// channels on the external analog multiplexer
`define TEL_NUM_CHANNELS 8

// width of the channel select, must cover TEL_NUM_CHANNELS
`define TEL_CHAN_W 3

// sample buffer slots
// also the number of credits the sequencer starts with
`define TEL_BUF_DEPTH 4

// clocks per serial bit
`define TEL_BIT_CYCLES 8

`endif
